// File: files.f
+incdir+src
src/uart_bridge_pkg.sv
src/uart_receive.sv
src/uart_transmit.sv
src/uart_control.sv
src/byte_fifo.sv
src/uart_bridge_top.sv
verification/tb_uart_bridge.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build the UART bridge testbench with Verilator, run it, look for the pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/100ps --top-module tb_uart_bridge \
   -f files.f -o tb_uart_bridge \
   && ./obj_dir/tb_uart_bridge | tee /dev/stderr \
      | grep -F '*** TEST PASSED ***' > /dev/null \
   && { echo "Simulation passed"; exit 0; } \
   || { echo "Simulation failed"; exit 1; }

// File: verification/tb_uart_bridge.sv
// --------------------
// UART bridge testbench
// Directed tests over the serial line and both byte streams
// --------------------
`timescale 1ns/100ps
`include "uart_bridge_cfg.svh"

module tb_uart_bridge;

   localparam int DIV             = `UART_DIVISOR;
   localparam int FRAME_CYCLES    = 10 * DIV;                   // Start, 8 data, stop
   // Worst-case frames per test in run order
   localparam int TEST_FRAMES     = 14 + 10 + 2 + 16 + 40;
   localparam int WATCHDOG_CYCLES = 16 + TEST_FRAMES * FRAME_CYCLES + 2000;
   localparam int WAIT_LIMIT      = 2 * FRAME_CYCLES;           // One handshake

   logic                          clk_io;
   logic                          rst_n;
   logic                          uart_rx;
   logic                          uart_cts;
   uart_bridge_pkg::stream_beat_t fifo_out_beat;
   logic                          fifo_in_ready;
   logic                          uart_tx;
   logic                          uart_rts;
   logic                          fifo_out_ready;
   uart_bridge_pkg::stream_beat_t fifo_in_beat;
   logic                          logic_rst;
   logic                          com_rst;
   logic                          error;
   int                            seed = 27058;
   int                            errors = 0;
   int                            checks = 0;
   int                            com_rst_pulses = 0;   // Cycles seen with com_rst high

   uart_bridge_top u_dut (
      .clk_io, .rst_n, .uart_rx, .uart_cts, .fifo_out_beat, .fifo_in_ready,
      .uart_tx, .uart_rts, .fifo_out_ready, .fifo_in_beat, .logic_rst, .com_rst, .error
   );

   initial begin
      clk_io = 1'b0;
      forever #20 clk_io = ~clk_io;   // 40 ns period
   end

   always @(negedge clk_io) begin
      if (com_rst)
         com_rst_pulses++;
   end

   initial begin
      repeat (WATCHDOG_CYCLES) @(posedge clk_io);
      $display("Timeout, tests still running after %0d cycles", WATCHDOG_CYCLES);
      $display("*** TEST FAILED ***");
      $finish;
   end

   task automatic check_beat(input string name, input uart_bridge_pkg::stream_beat_t want,
                             input uart_bridge_pkg::stream_beat_t got);
      checks++;
      if (got !== want) begin
         errors++;
         $display("ERR %0t %s expected %h got %h", $time, name, want, got);
      end
   endtask

   task automatic check_bit(input string name, input logic want, input logic got);
      checks++;
      if (got !== want) begin
         errors++;
         $display("ERR %0t %s expected %b got %b", $time, name, want, got);
      end
   endtask

   task automatic check_byte(input string name, input logic [7:0] want, input logic [7:0] got);
      checks++;
      if (got !== want) begin
         errors++;
         $display("ERR %0t %s expected %h got %h", $time, name, want, got);
      end
   endtask

   function automatic logic [7:0] random_byte();
      logic [31:0] r;
      r = $random(seed);
      return r[7:0];
   endfunction

   // Host side frame with LSB first
   task automatic send_serial_byte(input logic [7:0] b, input logic bad_stop = 1'b0);
      int i;
      @(negedge clk_io);
      uart_rx = 1'b0;   // Start bit
      repeat (DIV) @(negedge clk_io);
      for (i = 0; i < 8; i++) begin
         uart_rx = b[i];
         repeat (DIV) @(negedge clk_io);
      end
      if (bad_stop) begin
         // Low only past the stop sample point, then idle one more bit
         uart_rx = 1'b0;
         repeat (DIV * 3 / 4) @(negedge clk_io);
         uart_rx = 1'b1;
         repeat (DIV / 4 + DIV) @(negedge clk_io);
      end else begin
         uart_rx = 1'b1;
         repeat (DIV) @(negedge clk_io);
      end
   endtask

   // Data byte as the host sends it with the escape doubled
   task automatic send_stream_byte(input logic [7:0] b);
      send_serial_byte(b);
      if (b == `ESC_BYTE)
         send_serial_byte(b);
   endtask

   task automatic recv_serial_byte(output logic [7:0] b);
      int wait_cycles;
      int i;
      wait_cycles = 0;
      b = 8'h00;
      @(negedge clk_io);
      while (uart_tx !== 1'b0 && wait_cycles < WAIT_LIMIT) begin
         @(negedge clk_io);
         wait_cycles++;
      end
      if (uart_tx !== 1'b0) begin
         errors++;
         $display("No start bit on uart_tx within %0d cycles", WAIT_LIMIT);
      end else begin
         repeat (DIV / 2) @(negedge clk_io);   // Middle of start bit
         check_bit("uart_tx start", 1'b0, uart_tx);
         for (i = 0; i < 8; i++) begin
            repeat (DIV) @(negedge clk_io);
            b[i] = uart_tx;
         end
         repeat (DIV) @(negedge clk_io);
         check_bit("uart_tx stop", 1'b1, uart_tx);
      end
   endtask

   task automatic push_beat(input logic [7:0] b);
      int wait_cycles;
      wait_cycles = 0;
      @(negedge clk_io);
      while (!fifo_out_ready && wait_cycles < WAIT_LIMIT) begin
         @(negedge clk_io);
         wait_cycles++;
      end
      if (!fifo_out_ready) begin
         errors++;
         $display("fifo_out_ready stayed low, byte %h was not pushed", b);
      end else begin
         fifo_out_beat.valid = 1'b1;
         fifo_out_beat.data  = b;
         @(negedge clk_io);           // Written at the rising edge in between
         fifo_out_beat.valid = 1'b0;
      end
   endtask

   task automatic pop_beat(input logic [7:0] want);
      int wait_cycles;
      wait_cycles = 0;
      @(negedge clk_io);
      while (!fifo_in_beat.valid && wait_cycles < WAIT_LIMIT) begin
         @(negedge clk_io);
         wait_cycles++;
      end
      check_beat("fifo_in_beat", {1'b1, want}, fifo_in_beat);
      fifo_in_ready = 1'b1;   // One transfer
      @(negedge clk_io);
      fifo_in_ready = 1'b0;
   endtask

   task automatic ingress_order();
      logic [7:0] sent_q[$];
      logic [7:0] b;
      int         i;
      for (i = 0; i < 6; i++) begin
         b = random_byte();
         send_stream_byte(b);
         sent_q.push_back(b);
      end
      send_stream_byte(`ESC_BYTE);   // FE FE on the line gives one stored FE
      sent_q.push_back(`ESC_BYTE);
      while (sent_q.size() > 0)
         pop_beat(sent_q.pop_front());
      check_bit("fifo_in_beat.valid", 1'b0, fifo_in_beat.valid);
   endtask

   task automatic egress_order();
      logic [7:0] line_q[$];   // Bytes as they should appear on uart_tx
      logic [7:0] b;
      logic [7:0] got;
      int         i;
      @(negedge clk_io);
      uart_cts = 1'b1;   // Hold frames until all bytes are queued
      for (i = 0; i < 5; i++) begin
         b = (i == 2) ? `ESC_BYTE : random_byte();
         push_beat(b);
         line_q.push_back(b);
         if (b == `ESC_BYTE)
            line_q.push_back(b);   // Sent twice
      end
      uart_cts = 1'b0;
      while (line_q.size() > 0) begin
         recv_serial_byte(got);
         check_byte("uart_tx byte", line_q.pop_front(), got);
      end
   endtask

   task automatic clear_to_send();
      logic [7:0] got;
      logic       left_idle;
      int         i;
      left_idle = 1'b0;
      @(negedge clk_io);
      uart_cts = 1'b1;
      push_beat(8'h3C);
      for (i = 0; i < FRAME_CYCLES; i++) begin
         @(negedge clk_io);
         if (uart_tx !== 1'b1)
            left_idle = 1'b1;
      end
      if (left_idle) begin
         errors++;
         $display("uart_tx left idle while uart_cts was high");
      end
      uart_cts = 1'b0;
      recv_serial_byte(got);
      check_byte("uart_tx byte", 8'h3C, got);
   endtask

   task automatic host_commands();
      int pulses;
      send_serial_byte(`ESC_BYTE);
      send_serial_byte(8'h01);
      check_bit("logic_rst", 1'b1, logic_rst);
      send_serial_byte(`ESC_BYTE);
      send_serial_byte(8'h00);
      check_bit("logic_rst", 1'b0, logic_rst);
      send_serial_byte(`ESC_BYTE);
      send_serial_byte(8'h01);          // Set again so the flush can keep it
      send_serial_byte(8'h81, 1'b1);    // Framing error
      check_bit("error", 1'b1, error);
      send_stream_byte(8'h5A);
      check_beat("fifo_in_beat", {1'b1, 8'h5A}, fifo_in_beat);
      pulses = com_rst_pulses;
      send_serial_byte(`ESC_BYTE);
      send_serial_byte(8'h02);
      if (com_rst_pulses - pulses != 1) begin
         errors++;
         $display("com_rst high for %0d cycles after FE 02, one expected",
                  com_rst_pulses - pulses);
      end
      check_bit("error", 1'b0, error);
      check_bit("fifo_in_beat.valid", 1'b0, fifo_in_beat.valid);
      check_bit("logic_rst", 1'b1, logic_rst);
      send_serial_byte(`ESC_BYTE);
      send_serial_byte(8'h00);
      check_bit("logic_rst", 1'b0, logic_rst);
   endtask

   task automatic flow_and_errors();
      logic [7:0] kept_q[$];
      logic [7:0] b;
      int         n;
      send_serial_byte(`ESC_BYTE);
      send_serial_byte(8'h05);   // Unknown code
      check_bit("error", 1'b1, error);
      send_serial_byte(`ESC_BYTE);
      send_serial_byte(8'h02);
      check_bit("error", 1'b0, error);
      // Reader stalled so the FIFO fills then overflows
      for (n = 1; n <= `BRIDGE_FIFO_DEPTH + 2; n++) begin
         b = random_byte();
         send_stream_byte(b);
         if (n <= `BRIDGE_FIFO_DEPTH)
            kept_q.push_back(b);   // Later bytes are lost
         check_bit("uart_rts", n >= `BRIDGE_FIFO_DEPTH - `BRIDGE_FIFO_AFULL, uart_rts);
         check_bit("error", n > `BRIDGE_FIFO_DEPTH, error);
      end
      while (kept_q.size() > 0)
         pop_beat(kept_q.pop_front());
      check_bit("fifo_in_beat.valid", 1'b0, fifo_in_beat.valid);
   endtask

   initial begin
      rst_n         = 1'b0;
      uart_rx       = 1'b1;   // Line idle
      uart_cts      = 1'b0;
      fifo_out_beat = '0;
      fifo_in_ready = 1'b0;
      repeat (16) @(posedge clk_io);
      @(negedge clk_io);
      rst_n = 1'b1;
      @(negedge clk_io);
      check_bit("uart_tx", 1'b1, uart_tx);
      check_bit("uart_rts", 1'b0, uart_rts);
      check_bit("error", 1'b0, error);
      check_bit("logic_rst", 1'b0, logic_rst);
      check_bit("com_rst", 1'b0, com_rst);
      check_bit("fifo_out_ready", 1'b1, fifo_out_ready);   // Egress FIFO empty
      check_bit("fifo_in_beat.valid", 1'b0, fifo_in_beat.valid);
      ingress_order();
      egress_order();
      clear_to_send();
      host_commands();
      flow_and_errors();
      $display("Checks: %0d, errors: %0d", checks, errors);
      if (errors == 0)
         $display("*** TEST PASSED ***");
      else
         $display("*** TEST FAILED ***");
      $finish;
   end

endmodule

// File: src/uart_bridge_top.sv
// --------------------
// UART bridge top
// Serial 8N1 link to byte streams with escapes,
// sticky error and rts flow control
// --------------------
`timescale 1ns/100ps

module uart_bridge_top (
   input  logic                          clk_io,
   input  logic                          rst_n,
   input  logic                          uart_rx,
   input  logic                          uart_cts,
   input  uart_bridge_pkg::stream_beat_t fifo_out_beat,
   input  logic                          fifo_in_ready,
   output logic                          uart_tx,
   output logic                          uart_rts,
   output logic                          fifo_out_ready,
   output uart_bridge_pkg::stream_beat_t fifo_in_beat,
   output logic                          logic_rst,
   output logic                          com_rst,
   output logic                          error
);

   uart_bridge_pkg::stream_beat_t rx_beat;
   uart_bridge_pkg::stream_beat_t ing_beat;
   uart_bridge_pkg::stream_beat_t eg_beat;
   logic                          rx_error;
   logic                          ctl_error;
   logic                          ing_ready;
   logic                          ing_afull;
   logic                          eg_ready;
   logic [7:0]                    tx_data;
   logic                          tx_enable;
   logic                          tx_done;
   logic                          tx_rst_n;

   assign tx_rst_n = rst_n && !com_rst;   // Flush aborts a frame in flight

   // Sticky until rst_n or a flush
   always_ff @(posedge clk_io) begin
      if (!rst_n || com_rst)
         error <= 1'b0;
      else
         error <= error || rx_error || ctl_error;
   end

   always_ff @(posedge clk_io) begin
      if (!rst_n)
         uart_rts <= 1'b0;
      else
         uart_rts <= ing_afull;   // Ask host to pause
   end

   uart_receive u_receive (
      .clk_io, .rst_n, .uart_rx, .rx_beat, .rx_error
   );

   uart_control u_control (
      .clk_io, .rst_n, .rx_beat, .ing_ready, .eg_beat, .tx_done,
      .ing_beat, .eg_ready, .tx_data, .tx_enable, .logic_rst, .com_rst, .ctl_error
   );

   // cts high holds back the next start bit only
   uart_transmit u_transmit (
      .clk_io, .rst_n (tx_rst_n), .tx_enable (tx_enable && !uart_cts), .tx_data,
      .uart_tx, .tx_done
   );

   byte_fifo u_ingress_fifo (
      .clk_io, .rst_n, .flush (com_rst), .wr_beat (ing_beat), .rd_ready (fifo_in_ready),
      .wr_ready (ing_ready), .rd_beat (fifo_in_beat), .almost_full (ing_afull)
   );

   // Egress fill level is not reported
   byte_fifo u_egress_fifo (
      .clk_io, .rst_n, .flush (com_rst), .wr_beat (fifo_out_beat), .rd_ready (eg_ready),
      .wr_ready (fifo_out_ready), .rd_beat (eg_beat), .almost_full ()
   );

endmodule

// File: src/byte_fifo.sv
// --------------------
// Byte FIFO
// Synchronous FWFT buffer with almost-full flag
// --------------------
`timescale 1ns/100ps
`include "uart_bridge_cfg.svh"

module byte_fifo #(
   parameter int DEPTH = `BRIDGE_FIFO_DEPTH,
   parameter int AFULL = `BRIDGE_FIFO_AFULL   // Free-entry margin
) (
   input  logic                          clk_io,
   input  logic                          rst_n,
   input  logic                          flush,
   input  uart_bridge_pkg::stream_beat_t wr_beat,
   input  logic                          rd_ready,
   output logic                          wr_ready,
   output uart_bridge_pkg::stream_beat_t rd_beat,
   output logic                          almost_full
);

   localparam int AW = $clog2(DEPTH);
   localparam int CW = AW + 1;

   logic [7:0]    mem [DEPTH];
   logic [AW-1:0] wr_ptr;
   logic [AW-1:0] rd_ptr;
   logic [CW-1:0] count;     // Occupancy
   logic          do_wr;
   logic          do_rd;

   assign wr_ready      = count != CW'(DEPTH);
   assign rd_beat.valid = count != '0;
   assign rd_beat.data  = mem[rd_ptr];          // Head shows without a read
   assign almost_full   = count >= CW'(DEPTH - AFULL);
   assign do_wr         = wr_beat.valid && wr_ready;
   assign do_rd         = rd_beat.valid && rd_ready;

   always_ff @(posedge clk_io) begin
      if (!rst_n || flush) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (do_wr)
            wr_ptr <= (wr_ptr == AW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
         if (do_rd)
            rd_ptr <= (rd_ptr == AW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
         case ({do_wr, do_rd})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: ;   // Both or neither
         endcase
      end
   end

   always_ff @(posedge clk_io) begin
      if (do_wr)
         mem[wr_ptr] <= wr_beat.data;
   end

endmodule

// File: src/uart_control.sv
// --------------------
// UART bridge control
// Ingress unescape and host commands,
// egress escape doubling
// --------------------
`timescale 1ns/100ps
`include "uart_bridge_cfg.svh"

module uart_control (
   input  logic                          clk_io,
   input  logic                          rst_n,
   input  uart_bridge_pkg::stream_beat_t rx_beat,
   input  logic                          ing_ready,
   input  uart_bridge_pkg::stream_beat_t eg_beat,
   input  logic                          tx_done,
   output uart_bridge_pkg::stream_beat_t ing_beat,
   output logic                          eg_ready,
   output logic [7:0]                    tx_data,
   output logic                          tx_enable,
   output logic                          logic_rst,
   output logic                          com_rst,
   output logic                          ctl_error
);

   uart_bridge_pkg::ctl_state_e ing_state;
   uart_bridge_pkg::ctl_state_e eg_state;
   logic                        ing_valid;
   logic [7:0]                  ing_data;
   logic [7:0]                  eg_hold;     // Byte being sent
   logic                        fsm_clr;
   logic                        is_esc;
   logic                        cmd_valid;
   logic                        cmd_known;

   // com_rst restarts both machines but leaves logic_rst alone
   assign fsm_clr   = !rst_n || com_rst;
   assign is_esc    = rx_beat.data == `ESC_BYTE;
   assign cmd_valid = rx_beat.valid && ing_state == uart_bridge_pkg::CTL_ESCAPED && !is_esc;

   always_comb begin
      case (uart_bridge_pkg::esc_cmd_e'(rx_beat.data))
         uart_bridge_pkg::CMD_LOGIC_RELEASE,
         uart_bridge_pkg::CMD_LOGIC_RESET,
         uart_bridge_pkg::CMD_COM_RESET: cmd_known = 1'b1;
         default:                        cmd_known = 1'b0;
      endcase
   end

   // Ingress FSM, one registered beat per decoded data byte
   always_ff @(posedge clk_io) begin
      if (fsm_clr) begin
         ing_state <= uart_bridge_pkg::CTL_DATA;
         ing_valid <= 1'b0;
         ctl_error <= 1'b0;
      end else begin
         ing_valid <= 1'b0;
         ctl_error <= 1'b0;
         if (rx_beat.valid) begin
            if (ing_state == uart_bridge_pkg::CTL_DATA && is_esc) begin
               ing_state <= uart_bridge_pkg::CTL_ESCAPED;   // Hold off, wait for the code
            end else if (ing_state == uart_bridge_pkg::CTL_DATA || is_esc) begin
               // Plain byte or doubled escape
               ing_state <= uart_bridge_pkg::CTL_DATA;
               ing_valid <= ing_ready;
               ctl_error <= !ing_ready;                     // FIFO full, byte lost
            end else begin
               ing_state <= uart_bridge_pkg::CTL_DATA;
               ctl_error <= !cmd_known;
            end
         end
      end
   end

   always_ff @(posedge clk_io) begin
      if (rx_beat.valid)
         ing_data <= rx_beat.data;
   end

   assign ing_beat.valid = ing_valid;
   assign ing_beat.data  = ing_data;

   // Command outputs, only rst_n clears them
   always_ff @(posedge clk_io) begin
      if (!rst_n) begin
         logic_rst <= 1'b0;
         com_rst   <= 1'b0;
      end else begin
         com_rst <= 1'b0;   // Pulse
         if (cmd_valid) begin
            case (uart_bridge_pkg::esc_cmd_e'(rx_beat.data))
               uart_bridge_pkg::CMD_LOGIC_RELEASE: logic_rst <= 1'b0;
               uart_bridge_pkg::CMD_LOGIC_RESET:   logic_rst <= 1'b1;
               uart_bridge_pkg::CMD_COM_RESET:     com_rst   <= 1'b1;
               default:                            ;   // Flagged by ingress FSM
            endcase
         end
      end
   end

   // Egress FSM, one frame in flight at a time
   always_ff @(posedge clk_io) begin
      if (fsm_clr) begin
         eg_state <= uart_bridge_pkg::EG_IDLE;
      end else begin
         case (eg_state)
            uart_bridge_pkg::EG_IDLE: begin
               if (eg_beat.valid)
                  eg_state <= uart_bridge_pkg::EG_SEND;
            end
            uart_bridge_pkg::EG_SEND: begin
               if (tx_done)
                  eg_state <= (eg_hold == `ESC_BYTE) ? uart_bridge_pkg::EG_DOUBLE
                                                     : uart_bridge_pkg::EG_IDLE;
            end
            uart_bridge_pkg::EG_DOUBLE: begin
               if (tx_done)
                  eg_state <= uart_bridge_pkg::EG_IDLE;
            end
            default: eg_state <= uart_bridge_pkg::EG_IDLE;
         endcase
      end
   end

   always_ff @(posedge clk_io) begin
      if (eg_ready)
         eg_hold <= eg_beat.data;
   end

   assign eg_ready  = eg_state == uart_bridge_pkg::EG_IDLE && eg_beat.valid;   // Pop on accept
   assign tx_enable = eg_state == uart_bridge_pkg::EG_SEND ||
                      eg_state == uart_bridge_pkg::EG_DOUBLE;
   assign tx_data   = eg_hold;

endmodule

// File: src/uart_transmit.sv
// --------------------
// UART transmitter
// 8N1 serializer, one frame per enable
// --------------------
`timescale 1ns/100ps
`include "uart_bridge_cfg.svh"

module uart_transmit (
   input  logic       clk_io,
   input  logic       rst_n,
   input  logic       tx_enable,
   input  logic [7:0] tx_data,
   output logic       uart_tx,
   output logic       tx_done
);

   localparam int CW = $clog2(`UART_DIVISOR);

   uart_bridge_pkg::tx_state_e state;
   logic [CW-1:0]              div_cnt;
   logic [2:0]                 bit_cnt;
   logic [7:0]                 shift;     // Copy of tx_data taken at start
   logic                       tx_q;
   logic                       full_tick;

   assign full_tick = div_cnt == CW'(`UART_DIVISOR - 1);
   assign tx_done   = (state == uart_bridge_pkg::TX_STOP) && full_tick;   // Last stop cycle
   assign uart_tx   = tx_q;

   always_ff @(posedge clk_io) begin
      if (!rst_n) begin
         state   <= uart_bridge_pkg::TX_IDLE;
         div_cnt <= '0;
         bit_cnt <= '0;
         tx_q    <= 1'b1;   // Idle high
      end else begin
         div_cnt <= full_tick ? '0 : div_cnt + 1'b1;
         case (state)
            uart_bridge_pkg::TX_IDLE: begin
               div_cnt <= '0;
               if (tx_enable) begin
                  tx_q  <= 1'b0;                      // Start bit
                  state <= uart_bridge_pkg::TX_START;
               end
            end
            uart_bridge_pkg::TX_START: begin
               if (full_tick) begin
                  tx_q    <= shift[0];
                  bit_cnt <= '0;
                  state   <= uart_bridge_pkg::TX_DATA;
               end
            end
            uart_bridge_pkg::TX_DATA: begin
               if (full_tick) begin
                  bit_cnt <= bit_cnt + 1'b1;
                  if (bit_cnt == 3'd7) begin
                     tx_q  <= 1'b1;                   // Stop bit
                     state <= uart_bridge_pkg::TX_STOP;
                  end else begin
                     tx_q  <= shift[1];               // Next bit before the shift lands
                  end
               end
            end
            uart_bridge_pkg::TX_STOP: begin
               if (full_tick)
                  state <= uart_bridge_pkg::TX_IDLE;
            end
            default: state <= uart_bridge_pkg::TX_IDLE;
         endcase
      end
   end

   always_ff @(posedge clk_io) begin
      if (state == uart_bridge_pkg::TX_IDLE && tx_enable)
         shift <= tx_data;
      else if (state == uart_bridge_pkg::TX_DATA && full_tick)
         shift <= {1'b0, shift[7:1]};   // LSB first
   end

endmodule

// File: src/uart_receive.sv
// --------------------
// UART receiver
// 8N1 deserializer, mid-bit sampling,
// framing error on a low stop bit
// --------------------
`timescale 1ns/100ps
`include "uart_bridge_cfg.svh"

module uart_receive (
   input  logic                          clk_io,
   input  logic                          rst_n,
   input  logic                          uart_rx,
   output uart_bridge_pkg::stream_beat_t rx_beat,
   output logic                          rx_error
);

   localparam int CW = $clog2(`UART_DIVISOR);

   logic [1:0]                 rx_sync;      // Two-flop synchronizer
   logic                       rx_s;
   uart_bridge_pkg::rx_state_e state;
   logic [CW-1:0]              div_cnt;
   logic [2:0]                 bit_cnt;
   logic [7:0]                 shift;        // LSB arrives first
   logic                       beat_valid;
   logic                       half_tick;
   logic                       full_tick;

   assign rx_s      = rx_sync[1];
   assign half_tick = div_cnt == CW'(`UART_DIVISOR / 2 - 1);   // Middle of start bit
   assign full_tick = div_cnt == CW'(`UART_DIVISOR - 1);       // One bit later

   // Line idles high
   always_ff @(posedge clk_io) begin
      if (!rst_n) begin
         rx_sync <= 2'b11;
      end else begin
         rx_sync <= {rx_sync[0], uart_rx};
      end
   end

   always_ff @(posedge clk_io) begin
      if (!rst_n) begin
         state      <= uart_bridge_pkg::RX_IDLE;
         div_cnt    <= '0;
         bit_cnt    <= '0;
         beat_valid <= 1'b0;
         rx_error   <= 1'b0;
      end else begin
         beat_valid <= 1'b0;            // Both are single-cycle pulses
         rx_error   <= 1'b0;
         div_cnt    <= div_cnt + 1'b1;
         case (state)
            uart_bridge_pkg::RX_IDLE: begin
               div_cnt <= '0;
               if (!rx_s)
                  state <= uart_bridge_pkg::RX_START;
            end
            uart_bridge_pkg::RX_START: begin
               if (half_tick) begin
                  div_cnt <= '0;
                  bit_cnt <= '0;
                  // Glitch shorter than half a bit goes back to idle
                  state   <= rx_s ? uart_bridge_pkg::RX_IDLE : uart_bridge_pkg::RX_DATA;
               end
            end
            uart_bridge_pkg::RX_DATA: begin
               if (full_tick) begin
                  div_cnt <= '0;
                  bit_cnt <= bit_cnt + 1'b1;
                  if (bit_cnt == 3'd7)
                     state <= uart_bridge_pkg::RX_STOP;
               end
            end
            uart_bridge_pkg::RX_STOP: begin
               if (full_tick) begin
                  beat_valid <= rx_s;     // Good frame
                  rx_error   <= !rx_s;    // Framing error, byte dropped
                  state      <= uart_bridge_pkg::RX_IDLE;
               end
            end
            default: state <= uart_bridge_pkg::RX_IDLE;
         endcase
      end
   end

   // Sample data bits at their middle
   always_ff @(posedge clk_io) begin
      if (state == uart_bridge_pkg::RX_DATA && full_tick)
         shift <= {rx_s, shift[7:1]};
   end

   assign rx_beat.valid = beat_valid;
   assign rx_beat.data  = shift;

endmodule

// File: src/uart_bridge_pkg.sv
// --------------------
// UART bridge types
// Stream beat and FSM and command encodings
// --------------------
package uart_bridge_pkg;

   // One byte on any internal byte path
   typedef struct packed {
      logic       valid;   // Beat present
      logic [7:0] data;    // Payload byte
   } stream_beat_t;

   // Codes that may follow an escape from the host
   typedef enum logic [7:0] {
      CMD_LOGIC_RELEASE = 8'h00,   // Drop logic_rst
      CMD_LOGIC_RESET   = 8'h01,   // Raise logic_rst
      CMD_COM_RESET     = 8'h02    // Flush the bridge
   } esc_cmd_e;

   typedef enum logic [1:0] {
      RX_IDLE,    // Wait for falling edge
      RX_START,   // Confirm start at mid bit
      RX_DATA,    // 8 data samples
      RX_STOP     // Stop bit check
   } rx_state_e;

   typedef enum logic [1:0] {
      TX_IDLE,
      TX_START,
      TX_DATA,
      TX_STOP
   } tx_state_e;

   // Ingress and egress machines share one encoding
   typedef enum logic [2:0] {
      CTL_DATA,      // Ingress, plain bytes
      CTL_ESCAPED,   // Ingress, escape seen
      EG_IDLE,       // Egress, wait for a byte
      EG_SEND,       // Egress, first copy
      EG_DOUBLE      // Egress, repeat of 0xFE
   } ctl_state_e;

endpackage

// File: src/uart_bridge_cfg.svh
// --------------------
// UART bridge configuration
// Line timing, FIFO sizing and the escape byte
// --------------------
`ifndef UART_BRIDGE_CFG_SVH
`define UART_BRIDGE_CFG_SVH

// Clock cycles per serial bit
// Kept small so a frame is only 160 cycles
`define UART_DIVISOR 16

// Entries in each byte FIFO
`define BRIDGE_FIFO_DEPTH 16

// Free entries left when almost_full rises
// Leaves room for bytes already in flight on the line
`define BRIDGE_FIFO_AFULL 4

// In-band escape, doubled when sent as data
`define ESC_BYTE 8'hFE

`endif
